/* verilog/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

	////////////////////////////////////////////////////////////
	// Tile RAM geometry
	////////////////////////////////////////////////////////////

	localparam int TILE_W = 6;
	localparam int ROW_W = 5;
	localparam int COL_W = 6;
	localparam int ADDR_W = ROW_W + COL_W;

	// Playfield placement in tile coordinates
	localparam int BOARD_X0 = 10;
	localparam int BOARD_Y0 = 5;
	localparam int BOARD_W = 10;
	localparam int BOARD_H = 19;
	// Relative column of a new piece, row is always 0
	localparam int SPAWN_COL = 4;

	// Shapes and rotations
	localparam int NUM_SHAPES = 7;
	localparam int SHAPE_W = 3;
	localparam int ROT_W = 2;
	localparam int OFF_W = 2;

	////////////////////////////////////////////////////////////
	// Frame timing
	////////////////////////////////////////////////////////////

	localparam int GRAVITY_FRAMES = 3;
	localparam int GRAV_W = 2;
	localparam int STEP_W = 4;

	localparam int STEP_READ_FIRST = 1;
	localparam int STEP_READ_LAST = 4;
	localparam int STEP_RESULT = 6;
	localparam int STEP_ERASE_FIRST = 7;
	localparam int STEP_ERASE_LAST = 10;
	localparam int STEP_UPDATE = 11;
	localparam int STEP_DRAW_FIRST = 12;
	localparam int STEP_DRAW_LAST = 15;

	// Flat RAM address, or row and column fields
	typedef union packed {
		logic [ADDR_W-1:0] addr;
		struct packed {
			logic [ROW_W-1:0] row;
			logic [COL_W-1:0] col;
		} rc;
	} cell_addr_u;

	typedef enum logic [2:0] {
		MOVE_NONE,
		MOVE_FALL,
		MOVE_DOWN,
		MOVE_RIGHT,
		MOVE_LEFT,
		MOVE_ROT
	} move_e;

endpackage

`default_nettype wire

/* verilog/board_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Tile RAM ports, read data one cycle after address
interface board_bus_if;
	tetris_pkg::cell_addr_u rd_addr;
	logic [tetris_pkg::TILE_W-1:0] rd_data;
	tetris_pkg::cell_addr_u wr_addr;
	logic [tetris_pkg::TILE_W-1:0] wr_data;
	logic wr_en;

	// Collision reads
	modport reader (output rd_addr, input rd_data);
	// Erase and draw writes
	modport writer (output wr_addr, output wr_data, output wr_en);
	// RAM side
	modport memory (input rd_addr, output rd_data, input wr_addr, input wr_data, input wr_en);
endinterface

`default_nettype wire

/* verilog/piece_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Active piece as seen by checker and painter
interface piece_if;
	// Absolute cells of the piece now
	tetris_pkg::cell_addr_u cur_cells [4];
	// Absolute cells after the selected move
	tetris_pkg::cell_addr_u cand_cells [4];
	logic [tetris_pkg::TILE_W-1:0] color;
	// Blocked fall, piece stays and next shape spawns
	logic lock;

	modport driver (output cur_cells, output cand_cells, output color, output lock);
	modport sink (input cur_cells, input cand_cells, input color, input lock);
endinterface

`default_nettype wire

/* verilog/shape_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module shape_rom (
	input wire logic [tetris_pkg::SHAPE_W-1:0] shape,
	input wire logic [tetris_pkg::ROT_W-1:0] rot,
	output logic [3:0][tetris_pkg::OFF_W-1:0] row_off,
	output logic [3:0][tetris_pkg::OFF_W-1:0] col_off
);
	// One nibble per cell as {row, col} in the 4x4 box, cell 0 on top
	logic [15:0] cells;

	always_comb
	begin
		case ({shape, rot})
			// I, turns about the box center
			5'b001_00: cells = 16'h4567;
			5'b001_01: cells = 16'h26AE;
			5'b001_10: cells = 16'h89AB;
			5'b001_11: cells = 16'h159D;
			// O, same in every rotation
			5'b010_00: cells = 16'h569A;
			5'b010_01: cells = 16'h569A;
			5'b010_10: cells = 16'h569A;
			5'b010_11: cells = 16'h569A;
			// J, L, S, Z and T turn inside the top-left 3x3
			5'b011_00: cells = 16'h0456;
			5'b011_01: cells = 16'h1259;
			5'b011_10: cells = 16'h456A;
			5'b011_11: cells = 16'h1589;
			5'b100_00: cells = 16'h2456;
			5'b100_01: cells = 16'h159A;
			5'b100_10: cells = 16'h4568;
			5'b100_11: cells = 16'h0159;
			5'b101_00: cells = 16'h1245;
			5'b101_01: cells = 16'h156A;
			5'b101_10: cells = 16'h5689;
			5'b101_11: cells = 16'h0459;
			5'b110_00: cells = 16'h0156;
			5'b110_01: cells = 16'h2569;
			5'b110_10: cells = 16'h459A;
			5'b110_11: cells = 16'h1458;
			5'b111_00: cells = 16'h1456;
			5'b111_01: cells = 16'h1569;
			5'b111_10: cells = 16'h4569;
			5'b111_11: cells = 16'h1459;
			default: cells = 16'h0000;
		endcase
	end

	// Split nibbles into row and column offsets
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			row_off[i] = cells[15 - 4 * i -: tetris_pkg::OFF_W];
			col_off[i] = cells[13 - 4 * i -: tetris_pkg::OFF_W];
		end
	end
endmodule

`default_nettype wire

/* verilog/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
	input wire logic clk,
	input wire logic rst,
	input wire logic vblank,
	input wire logic [3:0] btn,
	output logic [tetris_pkg::STEP_W-1:0] step,
	output logic step_valid,
	output tetris_pkg::move_e move
);
	logic vblank_q;
	logic start;
	logic [tetris_pkg::GRAV_W-1:0] grav_cnt;

	// Rising vblank while idle, edges inside a frame are dropped
	assign start = vblank && !vblank_q && !step_valid;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vblank_q <= 1'b0;
			step <= '0;
			step_valid <= 1'b0;
			grav_cnt <= '0;
			move <= tetris_pkg::MOVE_NONE;
		end
		else
		begin
			vblank_q <= vblank;
			if (start)
			begin
				step_valid <= 1'b1;
				step <= '0;
				// One move per frame, gravity first
				if (grav_cnt == tetris_pkg::GRAV_W'(tetris_pkg::GRAVITY_FRAMES - 1))
				begin
					grav_cnt <= '0;
					move <= tetris_pkg::MOVE_FALL;
				end
				else
				begin
					grav_cnt <= grav_cnt + tetris_pkg::GRAV_W'(1);
					if (btn[3])
						move <= tetris_pkg::MOVE_DOWN;
					else if (btn[1])
						move <= tetris_pkg::MOVE_RIGHT;
					else if (btn[2])
						move <= tetris_pkg::MOVE_LEFT;
					else if (btn[0])
						move <= tetris_pkg::MOVE_ROT;
					else
						move <= tetris_pkg::MOVE_NONE;
				end
			end
			else if (step_valid)
			begin
				// Wraps back to 0 after the last step
				step <= step + tetris_pkg::STEP_W'(1);
				if (step == '1)
					step_valid <= 1'b0;
			end
		end
	end
endmodule

`default_nettype wire

/* verilog/collision_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module collision_checker (
	input wire logic clk,
	input wire logic rst,
	input wire logic [tetris_pkg::STEP_W-1:0] step,
	piece_if.sink piece,
	board_bus_if.reader bus,
	output logic blocked
);
	logic [tetris_pkg::STEP_W-1:0] rd_idx;
	logic [tetris_pkg::STEP_W-1:0] chk_idx;
	tetris_pkg::cell_addr_u chk_cell;
	logic own;
	logic hit;

	// Address for cell k goes out one step ahead of its read step
	assign rd_idx = step + tetris_pkg::STEP_W'(1) - tetris_pkg::STEP_W'(tetris_pkg::STEP_READ_FIRST);
	// Data for cell k arrives one step after its address
	assign chk_idx = step - tetris_pkg::STEP_W'(tetris_pkg::STEP_READ_FIRST + 1);
	assign chk_cell = piece.cand_cells[chk_idx[1:0]];

	always_comb
	begin
		// Tiles of the piece itself do not block
		own = 1'b0;
		for (int i = 0; i < 4; i++)
			own = own | (chk_cell.addr == piece.cur_cells[i].addr);
		hit = (chk_cell.rc.col < tetris_pkg::COL_W'(tetris_pkg::BOARD_X0))
			|| (chk_cell.rc.col >= tetris_pkg::COL_W'(tetris_pkg::BOARD_X0 + tetris_pkg::BOARD_W))
			|| (chk_cell.rc.row >= tetris_pkg::ROW_W'(tetris_pkg::BOARD_Y0 + tetris_pkg::BOARD_H))
			|| ((bus.rd_data != '0) && !own);
	end

	// Candidate cells 0 to 3 on the read port during steps 1 to 4
	always_ff @(posedge clk)
	begin
		if (rd_idx < tetris_pkg::STEP_W'(4))
			bus.rd_addr <= piece.cand_cells[rd_idx[1:0]];
	end

	// Sticky result, final from STEP_RESULT on
	always_ff @(posedge clk)
	begin
		if (rst)
			blocked <= 1'b0;
		else if (step == '0)
			blocked <= 1'b0;
		else if ((chk_idx < tetris_pkg::STEP_W'(4)) && hit)
			blocked <= 1'b1;
	end
endmodule

`default_nettype wire

/* verilog/piece_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_controller (
	input wire logic clk,
	input wire logic rst,
	input wire logic [tetris_pkg::STEP_W-1:0] step,
	input wire tetris_pkg::move_e move,
	input wire logic blocked,
	piece_if.driver piece
);
	// Position relative to the board's top-left cell
	logic [tetris_pkg::ROW_W-1:0] pos_row;
	logic [tetris_pkg::COL_W-1:0] pos_col;
	logic [tetris_pkg::ROT_W-1:0] rot;
	logic [tetris_pkg::ROT_W-1:0] rot_nxt;
	logic [tetris_pkg::SHAPE_W-1:0] shape;
	logic [3:0][tetris_pkg::OFF_W-1:0] cur_row_off;
	logic [3:0][tetris_pkg::OFF_W-1:0] cur_col_off;
	logic [3:0][tetris_pkg::OFF_W-1:0] nxt_row_off;
	logic [3:0][tetris_pkg::OFF_W-1:0] nxt_col_off;
	tetris_pkg::cell_addr_u cur [4];
	tetris_pkg::cell_addr_u cand [4];

	assign rot_nxt = rot + tetris_pkg::ROT_W'(1);

	// Offsets for the rotation now and one turn clockwise
	shape_rom rom_cur0 (.shape(shape), .rot(rot), .row_off(cur_row_off), .col_off(cur_col_off));
	shape_rom rom_nxt0 (.shape(shape), .rot(rot_nxt), .row_off(nxt_row_off), .col_off(nxt_col_off));

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			cur[i].rc.row = tetris_pkg::ROW_W'(tetris_pkg::BOARD_Y0) + pos_row
				+ tetris_pkg::ROW_W'(cur_row_off[i]);
			cur[i].rc.col = tetris_pkg::COL_W'(tetris_pkg::BOARD_X0) + pos_col
				+ tetris_pkg::COL_W'(cur_col_off[i]);
			cand[i] = cur[i];
			case (move)
				tetris_pkg::MOVE_FALL, tetris_pkg::MOVE_DOWN:
					cand[i].rc.row = cur[i].rc.row + tetris_pkg::ROW_W'(1);
				tetris_pkg::MOVE_RIGHT:
					cand[i].rc.col = cur[i].rc.col + tetris_pkg::COL_W'(1);
				// Never wraps, BOARD_X0 leaves room on the left
				tetris_pkg::MOVE_LEFT:
					cand[i].rc.col = cur[i].rc.col - tetris_pkg::COL_W'(1);
				tetris_pkg::MOVE_ROT:
				begin
					cand[i].rc.row = tetris_pkg::ROW_W'(tetris_pkg::BOARD_Y0) + pos_row
						+ tetris_pkg::ROW_W'(nxt_row_off[i]);
					cand[i].rc.col = tetris_pkg::COL_W'(tetris_pkg::BOARD_X0) + pos_col
						+ tetris_pkg::COL_W'(nxt_col_off[i]);
				end
				default:
					cand[i] = cur[i];
			endcase
		end
	end

	assign piece.cur_cells = cur;
	assign piece.cand_cells = cand;
	// Shape id doubles as tile color
	assign piece.color = tetris_pkg::TILE_W'(shape);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			shape <= tetris_pkg::SHAPE_W'(1);
			rot <= '0;
			pos_row <= '0;
			pos_col <= tetris_pkg::COL_W'(tetris_pkg::SPAWN_COL);
			piece.lock <= 1'b0;
		end
		else if (step == tetris_pkg::STEP_W'(tetris_pkg::STEP_RESULT))
			piece.lock <= (move == tetris_pkg::MOVE_FALL) && blocked;
		else if (step == tetris_pkg::STEP_W'(tetris_pkg::STEP_UPDATE))
		begin
			piece.lock <= 1'b0;
			if (piece.lock)
			begin
				// Piece stays in the RAM, next shape at spawn
				if (shape == tetris_pkg::SHAPE_W'(tetris_pkg::NUM_SHAPES))
					shape <= tetris_pkg::SHAPE_W'(1);
				else
					shape <= shape + tetris_pkg::SHAPE_W'(1);
				rot <= '0;
				pos_row <= '0;
				pos_col <= tetris_pkg::COL_W'(tetris_pkg::SPAWN_COL);
			end
			else if (!blocked)
			begin
				case (move)
					tetris_pkg::MOVE_FALL, tetris_pkg::MOVE_DOWN:
						pos_row <= pos_row + tetris_pkg::ROW_W'(1);
					tetris_pkg::MOVE_RIGHT:
						pos_col <= pos_col + tetris_pkg::COL_W'(1);
					tetris_pkg::MOVE_LEFT:
						pos_col <= pos_col - tetris_pkg::COL_W'(1);
					tetris_pkg::MOVE_ROT:
						rot <= rot_nxt;
					default:
						rot <= rot;
				endcase
			end
		end
	end
endmodule

`default_nettype wire

/* verilog/cell_painter.sv */
`timescale 1ns/1ps
`default_nettype none

module cell_painter (
	input wire logic clk,
	input wire logic rst,
	input wire logic [tetris_pkg::STEP_W-1:0] step,
	input wire logic step_valid,
	piece_if.sink piece,
	board_bus_if.writer bus
);
	logic erase_win;
	logic draw_win;
	// Which of the four cells is written this cycle
	logic [1:0] slot;

	assign erase_win = step_valid
		&& (step >= tetris_pkg::STEP_W'(tetris_pkg::STEP_ERASE_FIRST))
		&& (step <= tetris_pkg::STEP_W'(tetris_pkg::STEP_ERASE_LAST));
	assign draw_win = step_valid
		&& (step >= tetris_pkg::STEP_W'(tetris_pkg::STEP_DRAW_FIRST))
		&& (step <= tetris_pkg::STEP_W'(tetris_pkg::STEP_DRAW_LAST));

	// Restarts at 0 for every write burst
	always_ff @(posedge clk)
	begin
		if (rst)
			slot <= '0;
		else if (erase_win || draw_win)
			slot <= slot + 2'd1;
		else
			slot <= '0;
	end

	// Locked piece keeps its tiles, so no erase
	assign bus.wr_en = (erase_win && !piece.lock) || draw_win;
	// Draw uses cells already updated at STEP_UPDATE
	assign bus.wr_addr = piece.cur_cells[slot];
	assign bus.wr_data = draw_win ? piece.color : '0;
endmodule

`default_nettype wire

/* verilog/tetris_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_engine (
	input wire logic clk,
	input wire logic rst,
	input wire logic vblank,
	input wire logic [3:0] btn,
	output logic [tetris_pkg::ADDR_W-1:0] rd_addr,
	input wire logic [tetris_pkg::TILE_W-1:0] rd_data,
	output logic [tetris_pkg::ADDR_W-1:0] wr_addr,
	output logic [tetris_pkg::TILE_W-1:0] wr_data,
	output logic wr_en
);
	logic [tetris_pkg::STEP_W-1:0] step;
	logic step_valid;
	tetris_pkg::move_e move;
	logic blocked;

	board_bus_if bus0 ();
	piece_if piece0 ();

	////////////////////////////////////////////////////////////
	// Frame control and piece state
	////////////////////////////////////////////////////////////

	frame_sequencer seq0 (
		.clk(clk),
		.rst(rst),
		.vblank(vblank),
		.btn(btn),
		.step(step),
		.step_valid(step_valid),
		.move(move)
	);

	piece_controller ctrl0 (
		.clk(clk),
		.rst(rst),
		.step(step),
		.move(move),
		.blocked(blocked),
		.piece(piece0.driver)
	);

	////////////////////////////////////////////////////////////
	// Tile RAM access
	////////////////////////////////////////////////////////////

	collision_checker chk0 (
		.clk(clk),
		.rst(rst),
		.step(step),
		.piece(piece0.sink),
		.bus(bus0.reader),
		.blocked(blocked)
	);

	cell_painter paint0 (
		.clk(clk),
		.rst(rst),
		.step(step),
		.step_valid(step_valid),
		.piece(piece0.sink),
		.bus(bus0.writer)
	);

	// Memory side of the bus onto the plain RAM ports
	assign rd_addr = bus0.rd_addr.addr;
	assign bus0.rd_data = rd_data;
	assign wr_addr = bus0.wr_addr.addr;
	assign wr_data = bus0.wr_data;
	assign wr_en = bus0.wr_en;
endmodule

`default_nettype wire

/* tb/board_model.sv */
`timescale 1ns/1ps
`default_nettype none

module board_model (
	input wire logic clk,
	input wire logic rst,
	// Tile RAM as seen by the engine
	input wire logic [tetris_pkg::ADDR_W-1:0] rd_addr,
	output logic [tetris_pkg::TILE_W-1:0] rd_data,
	input wire logic [tetris_pkg::ADDR_W-1:0] wr_addr,
	input wire logic [tetris_pkg::TILE_W-1:0] wr_data,
	input wire logic wr_en,
	// Testbench access between frames
	input wire logic pre_en,
	input wire logic [tetris_pkg::ADDR_W-1:0] pre_addr,
	input wire logic [tetris_pkg::TILE_W-1:0] pre_data,
	input wire logic [tetris_pkg::ADDR_W-1:0] peek_addr,
	output logic [tetris_pkg::TILE_W-1:0] peek_data,
	// Reference piece advanced once per frame
	input wire logic frame_start,
	input wire logic [3:0] btn,
	output logic [3:0][tetris_pkg::ADDR_W-1:0] old_cells,
	output logic [3:0][tetris_pkg::ADDR_W-1:0] cand_cells,
	output logic [3:0][tetris_pkg::ADDR_W-1:0] new_cells,
	output logic [tetris_pkg::TILE_W-1:0] old_color,
	output logic [tetris_pkg::TILE_W-1:0] new_color,
	output logic lock
);
	logic [tetris_pkg::TILE_W-1:0] mem [1 << tetris_pkg::ADDR_W];
	// Piece state with position relative to the board corner
	int shape;
	int rot;
	int prow;
	int pcol;
	int grav;
	int nrot;
	int nrow;
	int ncol;
	int row;
	int col;
	logic blk;
	logic own;
	tetris_pkg::move_e mv;
	logic [3:0][tetris_pkg::ADDR_W-1:0] cur;
	logic [3:0][tetris_pkg::ADDR_W-1:0] cand;

	// Absolute cells of a shape turned clockwise in its box
	function automatic logic [3:0][tetris_pkg::ADDR_W-1:0] place(input int shp, input int turns,
		input int prw, input int pcl);
		int rc [8];
		int r [4];
		int c [4];
		int n;
		int t;
		logic [3:0][tetris_pkg::ADDR_W-1:0] a;
		// I and O turn in a 4x4 box and the rest in 3x3
		n = (shp <= 2) ? 4 : 3;
		// Four rows followed by four columns
		case (shp)
			1: rc = '{1, 1, 1, 1, 0, 1, 2, 3};
			2: rc = '{1, 1, 2, 2, 1, 2, 1, 2};
			3: rc = '{0, 1, 1, 1, 0, 0, 1, 2};
			4: rc = '{0, 1, 1, 1, 2, 0, 1, 2};
			5: rc = '{0, 0, 1, 1, 1, 2, 0, 1};
			6: rc = '{0, 0, 1, 1, 0, 1, 1, 2};
			7: rc = '{0, 1, 1, 1, 1, 0, 1, 2};
			default: rc = '{0, 0, 0, 0, 0, 0, 0, 0};
		endcase
		for (int i = 0; i < 4; i++)
		begin
			r[i] = rc[i];
			c[i] = rc[i + 4];
		end
		for (int k = 0; k < turns; k++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				t = r[i];
				r[i] = c[i];
				c[i] = n - 1 - t;
			end
		end
		for (int i = 0; i < 4; i++)
			a[i] = {tetris_pkg::ROW_W'(tetris_pkg::BOARD_Y0 + prw + r[i]),
				tetris_pkg::COL_W'(tetris_pkg::BOARD_X0 + pcl + c[i])};
		return a;
	endfunction

	////////////////////////////////////////////////////////////
	// Tile RAM with read data one cycle late
	////////////////////////////////////////////////////////////

	initial
	begin
		rd_data = '0;
		for (int i = 0; i < (1 << tetris_pkg::ADDR_W); i++)
			mem[i] = '0;
	end

	always @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (pre_en)
			mem[pre_addr] <= pre_data;
	end

	assign peek_data = mem[peek_addr];

	////////////////////////////////////////////////////////////
	// Reference piece
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			shape = 1;
			rot = 0;
			prow = 0;
			pcol = tetris_pkg::SPAWN_COL;
			grav = 0;
			old_cells <= '0;
			cand_cells <= '0;
			new_cells <= '0;
			old_color <= '0;
			new_color <= '0;
			lock <= 1'b0;
		end
		else if (frame_start)
		begin
			cur = place(shape, rot, prow, pcol);
			// Gravity wins over every button
			if (grav == tetris_pkg::GRAVITY_FRAMES - 1)
			begin
				grav = 0;
				mv = tetris_pkg::MOVE_FALL;
			end
			else
			begin
				grav = grav + 1;
				if (btn[3])
					mv = tetris_pkg::MOVE_DOWN;
				else if (btn[1])
					mv = tetris_pkg::MOVE_RIGHT;
				else if (btn[2])
					mv = tetris_pkg::MOVE_LEFT;
				else if (btn[0])
					mv = tetris_pkg::MOVE_ROT;
				else
					mv = tetris_pkg::MOVE_NONE;
			end
			nrot = rot;
			nrow = prow;
			ncol = pcol;
			case (mv)
				tetris_pkg::MOVE_FALL, tetris_pkg::MOVE_DOWN: nrow = prow + 1;
				tetris_pkg::MOVE_RIGHT: ncol = pcol + 1;
				tetris_pkg::MOVE_LEFT: ncol = pcol - 1;
				tetris_pkg::MOVE_ROT: nrot = (rot + 1) % 4;
				default: nrot = rot;
			endcase
			cand = place(shape, nrot, nrow, ncol);
			// Walls, floor and foreign tiles
			blk = 1'b0;
			for (int i = 0; i < 4; i++)
			begin
				row = int'(cand[i][tetris_pkg::ADDR_W-1:tetris_pkg::COL_W]);
				col = int'(cand[i][tetris_pkg::COL_W-1:0]);
				own = 1'b0;
				for (int j = 0; j < 4; j++)
					own = own | (cand[i] == cur[j]);
				if (col < tetris_pkg::BOARD_X0
					|| col >= tetris_pkg::BOARD_X0 + tetris_pkg::BOARD_W
					|| row >= tetris_pkg::BOARD_Y0 + tetris_pkg::BOARD_H
					|| (mem[cand[i]] != '0 && !own))
					blk = 1'b1;
			end
			old_cells <= cur;
			cand_cells <= cand;
			old_color <= tetris_pkg::TILE_W'(shape);
			if (mv == tetris_pkg::MOVE_FALL && blk)
			begin
				// Piece stays and the next shape spawns
				lock <= 1'b1;
				shape = (shape == tetris_pkg::NUM_SHAPES) ? 1 : shape + 1;
				rot = 0;
				prow = 0;
				pcol = tetris_pkg::SPAWN_COL;
			end
			else
			begin
				lock <= 1'b0;
				if (!blk)
				begin
					rot = nrot;
					prow = nrow;
					pcol = ncol;
				end
			end
			new_cells <= place(shape, rot, prow, pcol);
			new_color <= tetris_pkg::TILE_W'(shape);
		end
	end
endmodule

`default_nettype wire

/* tb/tb_tetris_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_engine;
	localparam int NUM_TESTS = 11;
	localparam int FRAME_CYCLES = 20;

	typedef struct packed {
		logic [3:0] btn;
		logic [7:0] frames;
		logic [tetris_pkg::ADDR_W-1:0] pre_addr;
		logic [tetris_pkg::TILE_W-1:0] color;
		logic [3:0] locks;
	} stim_row_t;

	// Buttons, frames, preloaded cell or 0, color after the row, lock frames in the row
	stim_row_t stim [NUM_TESTS] = '{
		'{4'b0000, 8'd1, 11'd0, 6'd1, 4'd0},
		'{4'b0010, 8'd8, 11'd0, 6'd1, 4'd0},
		'{4'b0100, 8'd4, 11'd0, 6'd1, 4'd0},
		'{4'b0001, 8'd1, 11'd0, 6'd1, 4'd0},
		'{4'b0000, 8'd1, 11'd0, 6'd1, 4'd0},
		// Tile at row 12 col 13 sits in the turned I
		'{4'b0001, 8'd1, 11'd781, 6'd1, 4'd0},
		'{4'b0000, 8'd3, 11'd0, 6'd1, 4'd0},
		'{4'b1000, 8'd3, 11'd0, 6'd1, 4'd0},
		// Down to the floor and then a blocked fall
		'{4'b1000, 8'd8, 11'd0, 6'd2, 4'd1},
		// O lands on the locked I
		'{4'b1000, 8'd15, 11'd0, 6'd3, 4'd1},
		'{4'b0010, 8'd2, 11'd0, 6'd3, 4'd0}
	};

	logic clk;
	logic rst;
	logic vblank;
	logic [3:0] btn;
	logic [tetris_pkg::ADDR_W-1:0] rd_addr;
	logic [tetris_pkg::TILE_W-1:0] rd_data;
	logic [tetris_pkg::ADDR_W-1:0] wr_addr;
	logic [tetris_pkg::TILE_W-1:0] wr_data;
	logic wr_en;
	logic pre_en;
	logic [tetris_pkg::ADDR_W-1:0] pre_addr;
	logic [tetris_pkg::TILE_W-1:0] pre_data;
	logic [tetris_pkg::ADDR_W-1:0] peek_addr;
	logic [tetris_pkg::TILE_W-1:0] peek_data;
	logic frame_start;
	logic [3:0][tetris_pkg::ADDR_W-1:0] old_cells;
	logic [3:0][tetris_pkg::ADDR_W-1:0] cand_cells;
	logic [3:0][tetris_pkg::ADDR_W-1:0] new_cells;
	logic [tetris_pkg::TILE_W-1:0] old_color;
	logic [tetris_pkg::TILE_W-1:0] new_color;
	logic exp_lock;
	logic [tetris_pkg::TILE_W-1:0] last_color;
	int errors;
	int lock_cnt;
	int cycles;
	int limit;
	int pass_cnt;
	int fail_cnt;
	int errs_before;

	tetris_engine dut0 (
		.clk(clk),
		.rst(rst),
		.vblank(vblank),
		.btn(btn),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en(wr_en)
	);

	board_model model0 (
		.clk(clk),
		.rst(rst),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en(wr_en),
		.pre_en(pre_en),
		.pre_addr(pre_addr),
		.pre_data(pre_data),
		.peek_addr(peek_addr),
		.peek_data(peek_data),
		.frame_start(frame_start),
		.btn(btn),
		.old_cells(old_cells),
		.cand_cells(cand_cells),
		.new_cells(new_cells),
		.old_color(old_color),
		.new_color(new_color),
		.lock(exp_lock)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic expect_equal(input string what, input int got, input int expected);
		if (got != expected)
		begin
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			errors++;
		end
	endtask

	function automatic logic [3:0][tetris_pkg::ADDR_W-1:0] sort_cells(
		input logic [3:0][tetris_pkg::ADDR_W-1:0] a);
		logic [tetris_pkg::ADDR_W-1:0] t;
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3 - i; j++)
			begin
				if (a[j] > a[j + 1])
				begin
					t = a[j];
					a[j] = a[j + 1];
					a[j + 1] = t;
				end
			end
		end
		return a;
	endfunction

	// Write order inside a burst is free so cells compare as sets
	task automatic expect_cells(input string what, input logic [3:0][tetris_pkg::ADDR_W-1:0] got,
		input logic [3:0][tetris_pkg::ADDR_W-1:0] expected);
		logic [3:0][tetris_pkg::ADDR_W-1:0] sg;
		logic [3:0][tetris_pkg::ADDR_W-1:0] se;
		sg = sort_cells(got);
		se = sort_cells(expected);
		for (int i = 0; i < 4; i++)
			expect_equal(what, int'(sg[i]), int'(se[i]));
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic preload_cell(input logic [tetris_pkg::ADDR_W-1:0] addr);
		@(posedge clk);
		#10;
		pre_en = 1'b1;
		pre_addr = addr;
		pre_data = 6'h3F;
		@(posedge clk);
		#10;
		pre_en = 1'b0;
	endtask

	// One vblank edge and every step sampled mid cycle
	task automatic play_frame(input logic [3:0] b);
		logic [3:0][tetris_pkg::ADDR_W-1:0] fetched;
		logic [3:0][tetris_pkg::ADDR_W-1:0] erased;
		logic [3:0][tetris_pkg::ADDR_W-1:0] drawn;
		int n_erase;
		int n_draw;
		logic want;
		n_erase = 0;
		n_draw = 0;
		fetched = '0;
		erased = '0;
		drawn = '0;
		@(posedge clk);
		#10;
		btn = b;
		vblank = 1'b1;
		frame_start = 1'b1;
		@(posedge clk);
		#10;
		vblank = 1'b0;
		frame_start = 1'b0;
		// Steps 16 and 17 are idle and must stay quiet
		for (int s = 0; s < 18; s++)
		begin
			@(negedge clk);
			// Candidate reads go out on steps 1 to 4
			if (s >= 1 && s <= 4)
				fetched[s - 1] = rd_addr;
			want = ((s >= 7) && (s <= 10) && !exp_lock) || ((s >= 12) && (s <= 15));
			expect_equal($sformatf("wr_en at step %0d", s), int'(wr_en), int'(want));
			if (wr_en && want && s <= 10)
			begin
				expect_equal("erase data", int'(wr_data), 0);
				erased[n_erase] = wr_addr;
				n_erase++;
			end
			else if (wr_en && want)
			begin
				expect_equal("draw data", int'(wr_data), int'(new_color));
				drawn[n_draw] = wr_addr;
				n_draw++;
				last_color = wr_data;
			end
		end
		expect_cells("read cell", fetched, cand_cells);
		if (n_erase == 0)
		begin
			// Locked tiles keep the old color
			lock_cnt++;
			for (int i = 0; i < 4; i++)
			begin
				peek_addr = old_cells[i];
				#1;
				expect_equal("locked tile", int'(peek_data), int'(old_color));
			end
		end
		else
			expect_cells("erased cell", erased, old_cells);
		expect_cells("drawn cell", drawn, new_cells);
		@(posedge clk);
	endtask

	initial
	begin
		limit = 100;
		for (int t = 0; t < NUM_TESTS; t++)
			limit = limit + int'(stim[t].frames) * FRAME_CYCLES;
		errors = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		rst = 1'b1;
		vblank = 1'b0;
		btn = 4'b0000;
		pre_en = 1'b0;
		pre_addr = '0;
		pre_data = '0;
		peek_addr = '0;
		frame_start = 1'b0;
		last_color = '0;
		repeat (2) @(posedge clk);
		#10;
		rst = 1'b0;
		// No writes before the first frame
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			expect_equal("wr_en after reset", int'(wr_en), 0);
		end
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			errs_before = errors;
			lock_cnt = 0;
			if (stim[t].pre_addr != '0)
				preload_cell(stim[t].pre_addr);
			for (int f = 0; f < int'(stim[t].frames); f++)
				play_frame(stim[t].btn);
			expect_equal("color after test", int'(last_color), int'(stim[t].color));
			expect_equal("lock frames", lock_cnt, int'(stim[t].locks));
			if (errors == errs_before)
			begin
				pass_cnt++;
				$display("test %0d: btn %b, %0d frames, ok", t, stim[t].btn, stim[t].frames);
			end
			else
			begin
				fail_cnt++;
				$display("test %0d: btn %b, %0d frames, %0d errors", t, stim[t].btn,
					stim[t].frames, errors - errs_before);
			end
		end
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
			pass_cnt, fail_cnt, errors);
		if (errors == 0 && fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Cycle limit from the table length
	initial
	begin
		cycles = 0;
		#1;
		while (cycles < limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("Result: FAILED");
		$finish;
	end
endmodule

`default_nettype wire

/* tetris_engine.f */
verilog/tetris_pkg.sv
verilog/board_bus_if.sv
verilog/piece_if.sv
verilog/shape_rom.sv
verilog/frame_sequencer.sv
verilog/collision_checker.sv
verilog/piece_controller.sv
verilog/cell_painter.sv
verilog/tetris_engine.sv
tb/board_model.sv
tb/tb_tetris_engine.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_tetris_engine -f tetris_engine.f \
	|| { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_tetris_engine)
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
